// File: cpu_core_top.f
+incdir+rtl
rtl/cpu_isa_pkg.sv
rtl/cpu_pipe_pkg.sv
rtl/cpu_slot_if.sv
rtl/cpu_issue_queue.sv
rtl/cpu_hazard.sv
rtl/cpu_pipeline.sv
rtl/cpu_retire.sv
rtl/cpu_core_top.sv
sim/cpu_core_checker.sv
sim/cpu_core_tb.sv

// File: rtl/cpu_core_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the issue and hazard pipeline.
// Words enter on in_valid against credits returned on in_credit, pass the
// issue queue, the hazard unit and stages 1 to 3, and leave on out_valid
// once the consumer has granted a credit on out_credit.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_core_top (
	input  logic                 CLK,
	input  logic                 RSTb,
	input  logic                 in_valid,
	input  logic [`CPU_BITS-1:0] in_instr,
	output logic                 in_credit,
	input  logic                 out_credit,
	output logic                 out_valid,
	output logic [`CPU_BITS-1:0] out_instr
);

	logic [`CPU_STAGES:1][`CPU_REGISTER_BITS-1:0] stage_hazard_reg;
	logic [`CPU_STAGES:1]                          stage_modifies_flags;

	cpu_slot_if queue_if ();  // Queue head to hazard unit.
	cpu_slot_if issue_if ();  // Issued slot or bubble into stage 1.
	cpu_slot_if retire_if (); // Stage 3 to retire.

	cpu_issue_queue u_issue_queue (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.in_valid  (in_valid),
		.in_instr  (in_instr),
		.in_credit (in_credit),
		.q         (queue_if.sender)
	);

	cpu_hazard u_hazard (
		.q                    (queue_if.receiver),
		.issue                (issue_if.sender),
		.stage_hazard_reg     (stage_hazard_reg),
		.stage_modifies_flags (stage_modifies_flags)
	);

	cpu_pipeline u_pipeline (
		.CLK                  (CLK),
		.RSTb                 (RSTb),
		.issue                (issue_if.receiver),
		.retire               (retire_if.sender),
		.stage_hazard_reg     (stage_hazard_reg),
		.stage_modifies_flags (stage_modifies_flags)
	);

	cpu_retire u_retire (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.retire     (retire_if.receiver),
		.out_credit (out_credit),
		.out_valid  (out_valid),
		.out_instr  (out_instr)
	);

endmodule

// File: rtl/cpu_hazard.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Hazard unit. Decodes the word at the head of the issue queue, works
// out which register it writes and whether it sets the flags, and checks
// its reads against the hazards still pending in stages 1 to 3.
// A clean head issues and pops. Otherwise a bubble goes down the pipe.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_hazard (
	cpu_slot_if.receiver                                 q,
	cpu_slot_if.sender                                   issue,
	input logic [`CPU_STAGES:1][`CPU_REGISTER_BITS-1:0] stage_hazard_reg,
	input logic [`CPU_STAGES:1]                          stage_modifies_flags
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	logic [`CPU_BITS-1:0]          instr;
	instr_class_t                  cls;
	logic [`CPU_REGISTER_BITS-1:0] src_a;
	logic [`CPU_REGISTER_BITS-1:0] src_b;
	logic                          check_a;
	logic                          check_b;
	logic [`CPU_REGISTER_BITS-1:0] hazard_reg0;
	logic                          modifies_flags0;
	logic                          hazard;
	logic                          issue_ok;
	pipe_slot_t                    issue_slot;

	assign instr = q.slot.instr;
	assign cls   = class_of(instr);
	assign src_a = reg_src_a(instr);
	assign src_b = reg_src_b(instr);

	// R0 never waits on anything.
	assign check_a = reads_a(cls) && (src_a != REG_R0);
	assign check_b = reads_b(cls) && (src_b != REG_R0);

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write target of the head word.
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		hazard_reg0 = REG_R0;
		case (cls)
			CLS_ALU_RR, CLS_ALU_IMM, CLS_LOAD: hazard_reg0 = reg_dest(instr);
			CLS_BRANCH: begin
				if (is_link_branch(instr))
					hazard_reg0 = LINK_REG; // Return address.
			end
			default: ; // Stores and NOPs write nothing.
		endcase
	end

	assign modifies_flags0 = (cls == CLS_ALU_RR) || (cls == CLS_ALU_IMM);

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Hazard check against every stage in flight.
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		hazard = 1'b0;
		for (int s = 1; s <= `CPU_STAGES; s++) begin
			if (check_a && (src_a == stage_hazard_reg[s]))
				hazard = 1'b1;
			if (check_b && (src_b == stage_hazard_reg[s]))
				hazard = 1'b1;
			if (uses_flags(instr) && stage_modifies_flags[s])
				hazard = 1'b1; // Flags not settled yet.
		end
	end

	assign issue_ok = q.slot.valid && issue.advance && !hazard;

	always_comb begin
		issue_slot = SLOT_BUBBLE;
		if (issue_ok) begin
			issue_slot.valid          = 1'b1;
			issue_slot.instr          = instr;
			issue_slot.hazard_reg     = hazard_reg0;
			issue_slot.modifies_flags = modifies_flags0;
		end
	end

	assign issue.slot    = issue_slot;
	assign q.advance     = issue_ok;          // Pop the head as it issues.
	assign q.credit_hold = issue.credit_hold; // Pass the output stall upstream.

endmodule

// File: rtl/cpu_isa_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction format of the simplified 16-bit ISA.
// Class in 15:12, destination in 11:8, source A in 7:4, source B in 3:0.
// Branches use bit 11 for link and bit 10 for a flag condition.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "cpu_settings.svh"

package cpu_isa_pkg;

	typedef enum logic [3:0] {
		CLS_NOP     = 4'h0,
		CLS_ALU_RR  = 4'h1,
		CLS_ALU_IMM = 4'h2,
		CLS_LOAD    = 4'h3,
		CLS_STORE   = 4'h4,
		CLS_BRANCH  = 4'h5
	} instr_class_t;

	localparam logic [`CPU_REGISTER_BITS-1:0] REG_R0   = '0;
	localparam logic [`CPU_REGISTER_BITS-1:0] LINK_REG = `CPU_LINK_REGISTER;

	function automatic instr_class_t class_of(input logic [`CPU_BITS-1:0] instr);
		case (instr[15:12])
			4'h1: return CLS_ALU_RR;
			4'h2: return CLS_ALU_IMM;
			4'h3: return CLS_LOAD;
			4'h4: return CLS_STORE;
			4'h5: return CLS_BRANCH;
			default: return CLS_NOP; // Unused codes behave as NOP.
		endcase
	endfunction

	function automatic logic [`CPU_REGISTER_BITS-1:0] reg_dest(input logic [`CPU_BITS-1:0] instr);
		return instr[11:8];
	endfunction

	function automatic logic [`CPU_REGISTER_BITS-1:0] reg_src_a(input logic [`CPU_BITS-1:0] instr);
		return instr[7:4];
	endfunction

	function automatic logic [`CPU_REGISTER_BITS-1:0] reg_src_b(input logic [`CPU_BITS-1:0] instr);
		return instr[3:0];
	endfunction

	function automatic logic is_link_branch(input logic [`CPU_BITS-1:0] instr);
		return (class_of(instr) == CLS_BRANCH) && instr[11];
	endfunction

	function automatic logic uses_flags(input logic [`CPU_BITS-1:0] instr);
		return (class_of(instr) == CLS_BRANCH) && instr[10];
	endfunction

	// Which source fields a class really reads.
	function automatic logic reads_a(input instr_class_t cls);
		return cls inside {CLS_ALU_RR, CLS_ALU_IMM, CLS_LOAD, CLS_STORE};
	endfunction

	function automatic logic reads_b(input instr_class_t cls);
		return cls inside {CLS_ALU_RR, CLS_STORE};
	endfunction

endpackage

// File: rtl/cpu_issue_queue.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Input side of the pipeline. A small circular FIFO of instruction words
// filled by a credit-based fetch source. The head goes to the hazard unit
// as a slot, and each pop returns one credit on in_credit.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_issue_queue (
	input  logic                 CLK,
	input  logic                 RSTb,
	input  logic                 in_valid,
	input  logic [`CPU_BITS-1:0] in_instr,
	output logic                 in_credit,
	cpu_slot_if.sender           q
);
	import cpu_pipe_pkg::*;

	// Depth is a power of two, so the pointers wrap on their own.
	localparam int PTR_BITS = $clog2(`CPU_ISSUE_DEPTH);
	localparam int CNT_BITS = $clog2(`CPU_ISSUE_DEPTH + 1);

	logic [`CPU_BITS-1:0] mem [`CPU_ISSUE_DEPTH];
	logic [PTR_BITS-1:0]  wr_ptr;
	logic [PTR_BITS-1:0]  rd_ptr;
	logic [CNT_BITS-1:0]  count;
	logic                 empty;
	logic                 pop;
	pipe_slot_t           head;

	assign empty = (count == '0);
	assign pop   = q.advance && !empty && !q.credit_hold; // Never pop on a starved output.

	// Only valid and instr are known here.
	always_comb begin
		head       = SLOT_BUBBLE;
		head.valid = !empty;
		head.instr = mem[rd_ptr];
	end

	assign q.slot = head;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			in_credit <= 1'b0;
		end else begin
			if (in_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count     <= count + CNT_BITS'(in_valid) - CNT_BITS'(pop);
			in_credit <= pop; // One credit back per popped entry.
		end
	end

	always_ff @(posedge CLK) begin
		if (in_valid)
			mem[wr_ptr] <= in_instr;
	end

endmodule

// File: rtl/cpu_pipe_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pipeline slot carried from the issue queue through stages 1 to 3.
// A slot holds the instruction and the hazard it leaves behind.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "cpu_settings.svh"

package cpu_pipe_pkg;

	typedef struct packed {
		logic                          valid;
		logic [`CPU_BITS-1:0]          instr;
		logic [`CPU_REGISTER_BITS-1:0] hazard_reg;     // Zero means none.
		logic                          modifies_flags;
	} pipe_slot_t;

	// Empty slot, sent whenever nothing issues.
	localparam pipe_slot_t SLOT_BUBBLE = '0;

endpackage

// File: rtl/cpu_pipeline.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Processing stages 1 to 3. A shift register of slots that moves one
// stage per clock whenever the last stage may leave or is empty.
// The hazard register and flag bit of each stage go back to the hazard
// unit. An empty stage reports no hazard.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_pipeline (
	input  logic                                          CLK,
	input  logic                                          RSTb,
	cpu_slot_if.receiver                                  issue,
	cpu_slot_if.sender                                    retire,
	output logic [`CPU_STAGES:1][`CPU_REGISTER_BITS-1:0] stage_hazard_reg,
	output logic [`CPU_STAGES:1]                          stage_modifies_flags
);
	import cpu_pipe_pkg::*;

	pipe_slot_t stage [1:`CPU_STAGES];
	logic       shift;

	// Last stage leaves, or there is nothing in it to lose.
	assign shift = retire.advance || !stage[`CPU_STAGES].valid;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int s = 1; s <= `CPU_STAGES; s++)
				stage[s] <= SLOT_BUBBLE;
		end else if (shift) begin
			stage[1] <= issue.slot;
			for (int s = 2; s <= `CPU_STAGES; s++)
				stage[s] <= stage[s-1];
		end
	end

	assign issue.advance     = shift;
	assign issue.credit_hold = retire.credit_hold;
	assign retire.slot       = stage[`CPU_STAGES];

	// Hazard export, masked by each stage's valid bit.
	always_comb begin
		for (int s = 1; s <= `CPU_STAGES; s++) begin
			stage_hazard_reg[s]     = stage[s].valid ? stage[s].hazard_reg : '0;
			stage_modifies_flags[s] = stage[s].valid && stage[s].modifies_flags;
		end
	end

endmodule

// File: rtl/cpu_retire.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Output side. Counts credits granted by the consumer and retires one
// valid stage 3 slot per credit onto out_valid and out_instr.
// Empty slots pass without using a credit.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_retire (
	input  logic                 CLK,
	input  logic                 RSTb,
	cpu_slot_if.receiver         retire,
	input  logic                 out_credit,
	output logic                 out_valid,
	output logic [`CPU_BITS-1:0] out_instr
);

	localparam int CNT_BITS = `CPU_BITS;

	logic [CNT_BITS-1:0] credit_cnt;
	logic                has_credit;
	logic                accept;

	assign has_credit = (credit_cnt != '0);
	assign accept     = retire.slot.valid && has_credit;

	assign retire.advance     = !retire.slot.valid || has_credit;
	assign retire.credit_hold = retire.slot.valid && !has_credit; // Pipeline freezes.

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			credit_cnt <= '0;
			out_valid  <= 1'b0;
		end else begin
			credit_cnt <= credit_cnt + CNT_BITS'(out_credit) - CNT_BITS'(accept);
			out_valid  <= accept;
		end
	end

	always_ff @(posedge CLK) begin
		if (accept)
			out_instr <= retire.slot.instr;
	end

endmodule

// File: rtl/cpu_settings.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Build-wide sizes for the CPU issue and hazard pipeline.
// Include this header wherever a width, a depth or the link register
// number is needed. The RTL and the testbench share these values.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define CPU_BITS           16 // Instruction word width.
`define CPU_REGISTER_BITS  4  // Register select width.

// Issue queue depth, also the starting credit count of the fetch source.
`define CPU_ISSUE_DEPTH    4

`define CPU_STAGES         3  // Pipeline stages tracked for hazards.
`define CPU_LINK_REGISTER  15 // Written by a link branch.

`endif

// File: rtl/cpu_slot_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Slot link between two pipeline blocks.
// The sender presents a slot, the receiver answers with advance when
// it takes it, and with credit_hold while the output side has no credit.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface cpu_slot_if;
	import cpu_pipe_pkg::*;

	pipe_slot_t slot;
	logic       advance;
	logic       credit_hold;

	modport sender (
		output slot,
		input  advance,
		input  credit_hold
	);

	modport receiver (
		input  slot,
		output advance,
		output credit_hold
	);

endinterface

// File: run_sim.sh
#!/bin/sh
# Build and run the issue and hazard pipeline testbench with Verilator.

LOG=sim.log

verilator --binary --timing -Wno-fatal -f cpu_core_top.f \
	--top-module cpu_core_tb -o cpu_core_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/cpu_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failures found" "$LOG"; then
	exit 1
fi
if ! grep -q "All tests passed!" "$LOG"; then
	echo "Simulation ended without a result line"
	exit 1
fi
exit 0

// File: sim/cpu_core_checker.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Checker for the issue and hazard pipeline. Watches the top-level ports
// on the falling edge, tracks both credit protocols, and compares retired
// words, their latency and their hazard spacing with what the testbench
// queued through expect_word.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_core_checker (
	input logic                 CLK,
	input logic                 RSTb,
	input logic                 in_valid,
	input logic                 in_credit,
	input logic                 out_credit,
	input logic                 out_valid,
	input logic [`CPU_BITS-1:0] out_instr
);

	// Cycles from the drive edge to out_valid, one each for the queue write,
	// the issue, two stage moves and the retire register.
	localparam int LATENCY = 5;

	logic [`CPU_BITS-1:0] exp_instr [$];
	logic [3:1][7:0]      exp_gap [$];
	longint               in_cycle [$];
	longint               retire_cycle [1:3];
	longint               cycle;
	int                   src_credits;
	int                   out_credits;
	int                   errors = 0;
	int                   test_errors = 0;
	int                   tests_run = 0;
	int                   tests_failed = 0;
	bit                   latency_check = 1'b0;

	task automatic fail(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		errors++;
		test_errors++;
	endtask

	task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
		errors++;
		test_errors++;
	endtask

	task automatic expect_word(input logic [`CPU_BITS-1:0] w, input logic [3:1][7:0] gaps);
		exp_instr.push_back(w);
		exp_gap.push_back(gaps);
	endtask

	function automatic int pending();
		return exp_instr.size();
	endfunction

	task automatic set_latency_check(input bit on);
		latency_check = on;
	endtask

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Port monitor.
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(negedge CLK) begin
		logic [`CPU_BITS-1:0] w;
		logic [3:1][7:0]      g;
		longint               c;
		if (!RSTb) begin
			cycle       = 0;
			src_credits = `CPU_ISSUE_DEPTH;
			out_credits = 0;
			for (int k = 1; k <= 3; k++)
				retire_cycle[k] = -1000;
		end else begin
			cycle++;
			if (in_credit)
				src_credits++;
			if (src_credits > `CPU_ISSUE_DEPTH)
				fail("in_credit pulsed with no entry popped");
			if (in_valid) begin
				if (src_credits == 0)
					fail("source sent a word without a credit");
				else
					src_credits--;
				in_cycle.push_back(cycle);
			end
			if (out_credit)
				out_credits++;
			if (out_valid) begin
				if (out_credits == 0)
					fail("out_valid pulsed without a consumer credit");
				else
					out_credits--;
				if (exp_instr.size() == 0 || in_cycle.size() == 0) begin
					fail("out_valid pulsed with no word outstanding");
				end else begin
					w = exp_instr.pop_front();
					g = exp_gap.pop_front();
					c = in_cycle.pop_front();
					if (out_instr !== w)
						mismatch("out_instr", 32'(out_instr), 32'(w));
					if (latency_check && (cycle - c) != LATENCY)
						mismatch("out_valid latency", 32'(cycle - c), 32'(LATENCY));
					for (int k = 1; k <= 3; k++) begin
						if (g[k] != 0 && (cycle - retire_cycle[k]) < g[k])
							fail($sformatf("word %h retired too soon after its producer", w));
					end
					retire_cycle[3] = retire_cycle[2];
					retire_cycle[2] = retire_cycle[1];
					retire_cycle[1] = cycle;
				end
			end
		end
	end

	task automatic end_test(input string name);
		if (src_credits != `CPU_ISSUE_DEPTH)
			fail("credits returned on in_credit do not match the words popped");
		tests_run++;
		if (test_errors == 0) begin
			$display("PASS: %s", name);
		end else begin
			$display("FAIL: %s with %0d errors", name, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	task automatic report_counts();
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
	endtask

endmodule

// File: sim/cpu_core_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the issue and hazard pipeline. Models the credit-based
// fetch source and the consumer, runs the directed and random tests, and
// hands every sent word with its hazard spacing to the checker.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_core_tb;

	localparam int CLK_PERIOD     = 20;
	localparam int WORDS_TOTAL    = 1 + 24 + 60 + 12 + 30;
	localparam int TIMEOUT_CYCLES = WORDS_TOTAL * 8 + 400;

	logic                 CLK = 1'b0;
	logic                 RSTb;
	logic                 in_valid;
	logic [`CPU_BITS-1:0] in_instr;
	logic                 in_credit;
	logic                 out_credit;
	logic                 out_valid;
	logic [`CPU_BITS-1:0] out_instr;

	int                   credit_mode = 0;  // 0 withheld, 1 every cycle, 2 random.
	logic [31:0]          stim_state = 32'd84;
	logic [31:0]          credit_state = 32'd84;
	int                   sent_cnt = 0;
	int                   returned = 0;
	logic [`CPU_BITS-1:0] sent_hist [$];

	cpu_core_top uut (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.in_valid   (in_valid),
		.in_instr   (in_instr),
		.in_credit  (in_credit),
		.out_credit (out_credit),
		.out_valid  (out_valid),
		.out_instr  (out_instr)
	);

	cpu_core_checker cpu_core_checker (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.in_valid   (in_valid),
		.in_credit  (in_credit),
		.out_credit (out_credit),
		.out_valid  (out_valid),
		.out_instr  (out_instr)
	);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Retire spacing a consumer needs from one earlier word, zero if none.
	function automatic int expected_hazard_gap(input logic [15:0] prod, input logic [15:0] cons);
		logic [3:0] p_cls;
		logic [3:0] c_cls;
		logic [3:0] wr;
		logic       p_flags;
		logic       dep;
		p_cls   = prod[15:12];
		c_cls   = cons[15:12];
		wr      = 4'd0;
		if (p_cls inside {4'h1, 4'h2, 4'h3})
			wr = prod[11:8];
		else if (p_cls == 4'h5 && prod[11])
			wr = 4'(`CPU_LINK_REGISTER);
		p_flags = (p_cls == 4'h1) || (p_cls == 4'h2);
		dep     = 1'b0;
		if (wr != 0 && (c_cls inside {4'h1, 4'h2, 4'h3, 4'h4}) && cons[7:4] == wr)
			dep = 1'b1;
		if (wr != 0 && (c_cls inside {4'h1, 4'h4}) && cons[3:0] == wr)
			dep = 1'b1;
		if (p_flags && c_cls == 4'h5 && cons[10])
			dep = 1'b1; // Conditional branch waits for the flags.
		return dep ? 3 : 0;
	endfunction

	// Credits handed back by the DUT, counted one cycle after each pulse.
	always @(posedge CLK) begin
		if (!RSTb)
			returned <= 0;
		else if (in_credit)
			returned <= returned + 1;
	end

	always @(posedge CLK) begin
		credit_state = lcg_next(credit_state);
		case (credit_mode)
			1:       out_credit <= 1'b1;
			2:       out_credit <= (credit_state[20:18] < 3'd3);
			default: out_credit <= 1'b0;
		endcase
	end

	task automatic send_word(input logic [`CPU_BITS-1:0] w);
		logic [3:1][7:0] gaps;
		for (int k = 1; k <= 3; k++)
			gaps[k] = (sent_hist.size() >= k) ?
				8'(expected_hazard_gap(sent_hist[sent_hist.size() - k], w)) : 8'd0;
		@(posedge CLK);
		while (`CPU_ISSUE_DEPTH + returned - sent_cnt <= 0) begin
			in_valid <= 1'b0;
			@(posedge CLK);
		end
		in_valid <= 1'b1;
		in_instr <= w;
		sent_cnt++;
		sent_hist.push_back(w);
		cpu_core_checker.expect_word(w, gaps);
	endtask

	task automatic send_random(input int n);
		logic [`CPU_BITS-1:0] w;
		repeat (n) begin
			stim_state = lcg_next(stim_state);
			w = {4'(stim_state[30:27] % 6), stim_state[26:15]};
			send_word(w);
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge CLK);
			in_valid <= 1'b0;
		end
	endtask

	task automatic drain();
		idle(1);
		while (cpu_core_checker.pending() != 0)
			@(posedge CLK);
		idle(4);
	endtask

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge CLK);
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Test failures found");
		$finish;
	end

	initial begin
		RSTb       <= 1'b0;
		in_valid   <= 1'b0;
		in_instr   <= '0;
		out_credit <= 1'b0;
		repeat (4) @(posedge CLK);
		RSTb <= 1'b1;

		// Quiet outputs after reset, then one word held until a credit.
		idle(6);
		send_word(16'h1123);
		idle(12);
		credit_mode <= 1;
		drain();
		cpu_core_checker.end_test("reset and first credit");

		// Independent ALU stream, R0 reads and writes included.
		cpu_core_checker.set_latency_check(1'b1);
		for (int i = 0; i < 24; i++)
			send_word({4'h1, 4'(i % 8), 4'(8 + i % 7), (i % 3 == 0) ? 4'h0 : 4'(9 + i % 6)});
		drain();
		cpu_core_checker.set_latency_check(1'b0);
		cpu_core_checker.end_test("independent stream latency");

		credit_mode <= 2;
		send_random(60);
		drain();
		cpu_core_checker.end_test("random words in order");

		credit_mode <= 1;
		send_word(16'h1512); // ALU r5, then a read of r5.
		send_word(16'h1651);
		send_word(16'h2700); // Store reads r7.
		send_word(16'h4070);
		send_word(16'h1123); // Conditional branch after an ALU word.
		send_word(16'h5400);
		send_word(16'h5800); // Link branch, then a read of R15.
		send_word(16'h11F2);
		send_word(16'h3900); // Load r9, then a read through source B.
		send_word(16'h1A09);
		send_word(16'h1003); // R0 write and R0 read.
		send_word(16'h1200);
		drain();
		cpu_core_checker.end_test("hazard spacing");

		// Back-pressure starts from a fresh reset, with no consumer credit banked.
		credit_mode <= 0;
		RSTb        <= 1'b0;
		repeat (4) @(posedge CLK);
		RSTb <= 1'b1;
		sent_cnt = 0;
		sent_hist.delete();
		fork
			send_random(30);
			begin
				repeat (40) @(posedge CLK);
				credit_mode <= 2;
			end
		join
		drain();
		cpu_core_checker.end_test("back-pressure");

		cpu_core_checker.report_counts();
		if (cpu_core_checker.errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule
